/* files.f */
+incdir+common
common/axi_resp_pkg.sv
common/link_pkg.sv
tx_channel/link_tx_channel.sv
design/online_delay.sv
design/phy_packer.sv
design/packet_slave_top.sv
verification/tb_checker.sv
verification/tb_top.sv

/* Makefile */
# Verilator build and run of the packet slave testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run tb_top and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -Wno-fatal -f files.f --top-module tb_top -Mdir obj_dir -o sim
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@if grep -q '^>>> FAIL$$' sim.log || ! grep -q '^>>> PASS$$' sim.log; then \
		echo "Result: simulation failed"; \
		exit 1; \
	else \
		echo "Result: simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

/* verification/tb_top.sv */
// Testbench for the packet slave transmit path
// Applies a table of R and B steps to UUT while tb_checker compares what reaches tx_phy

`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module tb_top;

  localparam int STEPS        = 12;
  localparam int DELAY_CYCLES = 5;
  localparam int WAIT_LIMIT   = 200;
  localparam int IDLE_CYCLES  = 8;
  localparam int R_INIT       = 2;
  localparam int B_INIT       = 2;

  // One table row; chan 0 is R and 1 is B
  typedef struct {
    int         chan;
    logic [3:0] id;
    logic [1:0] resp;
    logic       last;
    int         beats;
    int         returns;
    logic       toggle;
    int         r_init;
    int         b_init;
  } step_t;

  logic                       clk_wr;
  logic                       rst_n;
  logic                       tx_online;
  logic [`DELAY_WIDTH-1:0]    delay_value;
  logic [`CREDIT_WIDTH-1:0]   init_r_credit;
  logic [`CREDIT_WIDTH-1:0]   init_b_credit;
  logic [`LINK_PHY_WIDTH-1:0] tx_phy;
  logic [`LINK_PHY_WIDTH-1:0] rx_phy;
  logic [`AXI_ID_WIDTH-1:0]   user_rid;
  logic [`AXI_DATA_WIDTH-1:0] user_rdata;
  logic                       user_rlast;
  logic [1:0]                 user_rresp;
  logic                       user_rvalid;
  logic                       user_rready;
  logic [`AXI_ID_WIDTH-1:0]   user_bid;
  logic [1:0]                 user_bresp;
  logic                       user_bvalid;
  logic                       user_bready;

  logic        check_req;
  logic        expect_quiet;
  int          exp_r_pushes;
  int          exp_b_pushes;
  int          r_push_count;
  int          b_push_count;
  int          error_count;
  int          check_count;

  // Credit model of each channel
  int          r_credit_model;
  int          b_credit_model;
  int          r_pending;
  int          b_pending;
  logic [31:0] seed;
  step_t       steps[STEPS];

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  packet_slave_top UUT (
    .clk_wr (clk_wr), .rst_n (rst_n), .tx_online (tx_online), .delay_value (delay_value),
    .init_r_credit (init_r_credit), .init_b_credit (init_b_credit),
    .tx_phy (tx_phy), .rx_phy (rx_phy),
    .user_rid (user_rid), .user_rdata (user_rdata), .user_rlast (user_rlast),
    .user_rresp (user_rresp), .user_rvalid (user_rvalid), .user_rready (user_rready),
    .user_bid (user_bid), .user_bresp (user_bresp), .user_bvalid (user_bvalid),
    .user_bready (user_bready)
  );

  tb_checker u_checker (
    .clk_wr (clk_wr), .rst_n (rst_n),
    .user_rid (user_rid), .user_rdata (user_rdata), .user_rlast (user_rlast),
    .user_rresp (user_rresp), .user_rvalid (user_rvalid), .user_rready (user_rready),
    .user_bid (user_bid), .user_bresp (user_bresp), .user_bvalid (user_bvalid),
    .user_bready (user_bready), .tx_phy (tx_phy),
    .check_req (check_req), .expect_quiet (expect_quiet),
    .exp_r_pushes (exp_r_pushes), .exp_b_pushes (exp_b_pushes),
    .r_push_count (r_push_count), .b_push_count (b_push_count),
    .error_count (error_count), .check_count (check_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_cycle();
    @(posedge clk_wr);
    #2;
  endtask

  // Credit pulses in bits 1:0, random filler above them
  task automatic drive_rx(input logic r_ret, input logic b_ret);
    seed = xorshift32(seed);
    rx_phy = {seed[13:0], seed, ~seed, b_ret, r_ret};
  endtask

  // Beats go out while credit lasts, the rest waits in the buffer
  task automatic account(input int chan, input int beats, input int returns);
    int moved;
    if (chan == 0) begin
      r_pending      += beats;
      r_credit_model += returns;
      moved           = (r_pending < r_credit_model) ? r_pending : r_credit_model;
      r_pending      -= moved;
      r_credit_model -= moved;
      exp_r_pushes   += moved;
    end else begin
      b_pending      += beats;
      b_credit_model += returns;
      moved           = (b_pending < b_credit_model) ? b_pending : b_credit_model;
      b_pending      -= moved;
      b_credit_model -= moved;
      exp_b_pushes   += moved;
    end
  endtask

  task automatic wait_ready(input int chan, output logic ok);
    int n;
    n = 0;
    while (!((chan == 0) ? user_rready : user_bready) && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    ok = (chan == 0) ? user_rready : user_bready;
    if (!ok) begin
      $display("Timeout: %s ready stayed low for %0d cycles", (chan == 0) ? "R" : "B", n);
    end
  endtask

  ////////////////////
  // Link up and down
  task automatic bring_online(input int r_init, input int b_init, output logic ok);
    int n;
    init_r_credit = `CREDIT_WIDTH'(r_init);
    init_b_credit = `CREDIT_WIDTH'(b_init);
    expect_quiet  = 1'b1;
    tx_online     = 1'b1;
    // Ready must stay low through the whole delay
    repeat (DELAY_CYCLES) next_cycle();
    expect_quiet = 1'b0;
    n = 0;
    while (!(user_rready && user_bready) && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    ok = user_rready && user_bready;
    if (!ok) begin
      $display("Timeout: ready did not rise after tx_online went high");
    end
    r_credit_model = r_init;
    b_credit_model = b_init;
  endtask

  task automatic take_offline();
    tx_online = 1'b0;
    next_cycle();
    expect_quiet = 1'b1;
    // Buffered beats are lost with the link
    r_pending = 0;
    b_pending = 0;
    repeat (4) next_cycle();
  endtask

  task automatic send_beats(input step_t s, output logic ok);
    int k;
    ok = 1'b1;
    for (k = 0; k < s.beats; k++) begin
      seed = xorshift32(seed);
      if (s.chan == 0) begin
        user_rvalid = 1'b1;
        user_rid    = 4'(s.id + k);
        user_rdata  = seed;
        user_rlast  = s.last && (k == s.beats - 1);
        user_rresp  = s.resp;
      end else begin
        user_bvalid = 1'b1;
        user_bid    = 4'(s.id + k);
        user_bresp  = s.resp;
      end
      wait_ready(s.chan, ok);
      if (!ok) begin
        user_rvalid = 1'b0;
        user_bvalid = 1'b0;
        return;
      end
      // Ready seen high, so the handshake lands on this edge
      next_cycle();
    end
    user_rvalid = 1'b0;
    user_bvalid = 1'b0;
  endtask

  task automatic pulse_returns(input int chan, input int count);
    repeat (count) begin
      drive_rx(chan == 0, chan == 1);
      next_cycle();
    end
    drive_rx(1'b0, 1'b0);
  endtask

  // Waits for the modelled pushes, then lets the checker confirm no extra ones
  task automatic wait_pushes(output logic ok);
    int n;
    n = 0;
    while ((r_push_count < exp_r_pushes || b_push_count < exp_b_pushes) && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    ok = (r_push_count >= exp_r_pushes) && (b_push_count >= exp_b_pushes);
    if (!ok) begin
      $display("Timeout: expected pushes did not appear on tx_phy");
      return;
    end
    repeat (IDLE_CYCLES) next_cycle();
    check_req = 1'b1;
    next_cycle();
    check_req = 1'b0;
  endtask

  task automatic run_step(input step_t s, output logic ok);
    ok = 1'b1;
    if (s.toggle) begin
      take_offline();
      bring_online(s.r_init, s.b_init, ok);
      if (!ok) return;
    end
    send_beats(s, ok);
    if (!ok) return;
    account(s.chan, s.beats, 0);
    wait_pushes(ok);
    if (!ok) return;
    pulse_returns(s.chan, s.returns);
    account(s.chan, 0, s.returns);
    wait_pushes(ok);
  endtask

  task automatic print_result(input string what, input int errs_before, input logic ok);
    $display("%-32s %s", what, (ok && error_count == errs_before) ? "ok" : "failed");
  endtask

  ////////////////////
  // Main sequence
  initial begin : main_flow
    int   i;
    int   errs_before;
    int   done;
    logic ok;
    logic aborted;

    rst_n = 1'b0;
    tx_online = 1'b0;
    delay_value = `DELAY_WIDTH'(DELAY_CYCLES);
    init_r_credit = `CREDIT_WIDTH'(R_INIT);
    init_b_credit = `CREDIT_WIDTH'(B_INIT);
    rx_phy = '0;
    user_rid = '0;
    user_rdata = '0;
    user_rlast = 1'b0;
    user_rresp = 2'b00;
    user_rvalid = 1'b0;
    user_bid = '0;
    user_bresp = 2'b00;
    user_bvalid = 1'b0;
    check_req = 1'b0;
    expect_quiet = 1'b0;
    exp_r_pushes = 0;
    exp_b_pushes = 0;
    r_pending = 0;
    b_pending = 0;
    r_credit_model = 0;
    b_credit_model = 0;
    seed = 32'hc67dd18f;
    aborted = 1'b0;
    done = 0;

    // chan, id, resp, last, beats, returns, toggle, r_init, b_init
    steps[0]  = '{0, 4'h5, 2'b00, 1'b0, 2, 2, 1'b0, 0, 0};
    steps[1]  = '{1, 4'h9, 2'b10, 1'b0, 2, 2, 1'b0, 0, 0};
    // Three beats against two credits
    steps[2]  = '{0, 4'h1, 2'b01, 1'b1, 3, 1, 1'b0, 0, 0};
    steps[3]  = '{1, 4'hc, 2'b11, 1'b0, 3, 1, 1'b0, 0, 0};
    steps[4]  = '{0, 4'h0, 2'b00, 1'b0, 0, 2, 1'b0, 0, 0};
    // B beat left in the buffer without credit, dropped by the re-online
    steps[5]  = '{1, 4'h3, 2'b10, 1'b0, 1, 0, 1'b0, 0, 0};
    // Re-online with new credit values
    steps[6]  = '{0, 4'h7, 2'b00, 1'b1, 3, 0, 1'b1, 3, 1};
    steps[7]  = '{1, 4'h2, 2'b00, 1'b0, 1, 0, 1'b0, 0, 0};
    steps[8]  = '{0, 4'h4, 2'b10, 1'b0, 1, 0, 1'b0, 0, 0};
    steps[9]  = '{1, 4'h0, 2'b00, 1'b0, 0, 1, 1'b0, 0, 0};
    // B moves while R sits stalled
    steps[10] = '{1, 4'h6, 2'b01, 1'b0, 1, 0, 1'b0, 0, 0};
    steps[11] = '{0, 4'h0, 2'b00, 1'b0, 0, 1, 1'b0, 0, 0};

    repeat (3) @(posedge clk_wr);
    #2;
    rst_n = 1'b1;
    expect_quiet = 1'b1;
    repeat (2) next_cycle();

    errs_before = error_count;
    bring_online(R_INIT, B_INIT, ok);
    print_result("reset and online delay", errs_before, ok);
    aborted = !ok;

    for (i = 0; i < STEPS && !aborted; i++) begin
      errs_before = error_count;
      run_step(steps[i], ok);
      print_result($sformatf("step %0d %s beats %0d returns %0d%s", i,
                             (steps[i].chan == 0) ? "R" : "B", steps[i].beats,
                             steps[i].returns, steps[i].toggle ? " re-online" : ""),
                   errs_before, ok);
      aborted = !ok;
      done++;
    end

    $display("steps %0d of %0d, checks %0d, errors %0d", done, STEPS, check_count, error_count);
    if (aborted || error_count != 0) begin
      $display(">>> FAIL");
    end else begin
      $display(">>> PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tb_checker.sv */
// Watches the user handshakes and the PHY word of the packet slave and compares them
// Handshakes queue up per channel and every push on tx_phy is matched against the queue head

`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module tb_checker (
  input  logic                       clk_wr,
  input  logic                       rst_n,

  // DUT ports under watch
  input  logic [`AXI_ID_WIDTH-1:0]   user_rid,
  input  logic [`AXI_DATA_WIDTH-1:0] user_rdata,
  input  logic                       user_rlast,
  input  logic [1:0]                 user_rresp,
  input  logic                       user_rvalid,
  input  logic                       user_rready,
  input  logic [`AXI_ID_WIDTH-1:0]   user_bid,
  input  logic [1:0]                 user_bresp,
  input  logic                       user_bvalid,
  input  logic                       user_bready,
  input  logic [`LINK_PHY_WIDTH-1:0] tx_phy,

  // Requests from the stimulus side
  input  logic                       check_req,
  input  logic                       expect_quiet,
  input  int                         exp_r_pushes,
  input  int                         exp_b_pushes,

  output int                         r_push_count,
  output int                         b_push_count,
  output int                         error_count,
  output int                         check_count
);

  logic [`R_PAYLOAD_WIDTH-1:0] r_expected[$];
  logic [`B_PAYLOAD_WIDTH-1:0] b_expected[$];

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    error_count++;
  endtask

  always @(posedge clk_wr) begin
    if (!rst_n) begin
      r_expected.delete();
      b_expected.delete();
      r_push_count = 0;
      b_push_count = 0;
      error_count  = 0;
      check_count  = 0;
    end else begin
      ////////////////////
      // Accepted beats, packed as the PHY word carries them
      if (user_rvalid && user_rready) begin
        r_expected.push_back({user_rid, user_rdata, user_rlast, user_rresp});
      end
      if (user_bvalid && user_bready) begin
        b_expected.push_back({user_bid, user_bresp});
      end

      ////////////////////
      // R push on bit 0, payload in 39:1
      if (tx_phy[0]) begin
        check_count++;
        r_push_count++;
        if (r_expected.size() == 0) begin
          report_mismatch("R push on tx_phy with no accepted R beat");
        end else begin
          if (tx_phy[39:1] !== r_expected[0]) begin
            report_mismatch($sformatf("R payload %h, expected %h", tx_phy[39:1], r_expected[0]));
          end
          void'(r_expected.pop_front());
        end
      end else if (tx_phy[39:1] !== '0) begin
        report_mismatch($sformatf("R field %h without R push", tx_phy[39:1]));
      end

      // B push on bit 40, payload in 46:41
      if (tx_phy[40]) begin
        check_count++;
        b_push_count++;
        if (b_expected.size() == 0) begin
          report_mismatch("B push on tx_phy with no accepted B beat");
        end else begin
          if (tx_phy[46:41] !== b_expected[0]) begin
            report_mismatch($sformatf("B payload %h, expected %h", tx_phy[46:41], b_expected[0]));
          end
          void'(b_expected.pop_front());
        end
      end else if (tx_phy[46:41] !== '0) begin
        report_mismatch($sformatf("B field %h without B push", tx_phy[46:41]));
      end

      if (tx_phy[79:47] !== '0) begin
        report_mismatch($sformatf("Upper tx_phy bits %h not zero", tx_phy[79:47]));
      end

      ////////////////////
      // Link held down or still in its delay
      if (expect_quiet) begin
        check_count++;
        if (user_rready || user_bready) begin
          report_mismatch("Ready high while the link should be offline");
        end
        if (tx_phy !== '0) begin
          report_mismatch($sformatf("tx_phy %h not zero while offline", tx_phy));
        end
        // Buffered beats are dropped with the link
        r_expected.delete();
        b_expected.delete();
      end

      if (check_req) begin
        check_count++;
        if (r_push_count != exp_r_pushes) begin
          report_mismatch($sformatf("R pushes %0d, expected %0d", r_push_count, exp_r_pushes));
        end
        if (b_push_count != exp_b_pushes) begin
          report_mismatch($sformatf("B pushes %0d, expected %0d", b_push_count, exp_b_pushes));
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/packet_slave_top.sv */
// Transmit half of the AXI memory-mapped packet slave
// User R and B channels in, one 80-bit PHY word out, credit returns from the receive word

`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module packet_slave_top
  import axi_resp_pkg::*;
(
  input  logic                       clk_wr,
  input  logic                       rst_n,

  // Link control
  input  logic                       tx_online,
  input  logic [`DELAY_WIDTH-1:0]    delay_value,
  input  logic [`CREDIT_WIDTH-1:0]   init_r_credit,
  input  logic [`CREDIT_WIDTH-1:0]   init_b_credit,

  // PHY
  output logic [`LINK_PHY_WIDTH-1:0] tx_phy,
  input  logic [`LINK_PHY_WIDTH-1:0] rx_phy,

  // R channel
  input  logic [`AXI_ID_WIDTH-1:0]   user_rid,
  input  logic [`AXI_DATA_WIDTH-1:0] user_rdata,
  input  logic                       user_rlast,
  input  logic [1:0]                 user_rresp,
  input  logic                       user_rvalid,
  output logic                       user_rready,

  // B channel
  input  logic [`AXI_ID_WIDTH-1:0]   user_bid,
  input  logic [1:0]                 user_bresp,
  input  logic                       user_bvalid,
  output logic                       user_bready
);

  logic       link_online;
  r_payload_t r_user_payload;
  b_payload_t b_user_payload;
  r_payload_t r_push_payload;
  b_payload_t b_push_payload;
  logic       r_push;
  logic       b_push;
  logic       r_credit;
  logic       b_credit;

  ////////////////////
  // User fields into beat structs
  assign r_user_payload.id   = user_rid;
  assign r_user_payload.data = user_rdata;
  assign r_user_payload.last = user_rlast;
  assign r_user_payload.resp = axi_resp_e'(user_rresp);

  assign b_user_payload.id   = user_bid;
  assign b_user_payload.resp = axi_resp_e'(user_bresp);

  online_delay u_online_delay (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_online   (tx_online),
    .delay_value (delay_value),
    .link_online (link_online)
  );

  ////////////////////
  // Transmit channels
  link_tx_channel #(
    .PAYLOAD_WIDTH (`R_PAYLOAD_WIDTH),
    .CREDIT_MAX    (`R_CREDIT_MAX)
  ) u_r_chan (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .link_online   (link_online),
    .init_credit   (init_r_credit),
    .valid         (user_rvalid),
    .payload       (r_user_payload),
    .ready         (user_rready),
    .push          (r_push),
    .push_payload  (r_push_payload),
    .credit_return (r_credit)
  );

  link_tx_channel #(
    .PAYLOAD_WIDTH (`B_PAYLOAD_WIDTH),
    .CREDIT_MAX    (`B_CREDIT_MAX)
  ) u_b_chan (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .link_online   (link_online),
    .init_credit   (init_b_credit),
    .valid         (user_bvalid),
    .payload       (b_user_payload),
    .ready         (user_bready),
    .push          (b_push),
    .push_payload  (b_push_payload),
    .credit_return (b_credit)
  );

  phy_packer u_phy_packer (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .r_push    (r_push),
    .r_payload (r_push_payload),
    .b_push    (b_push),
    .b_payload (b_push_payload),
    .tx_phy    (tx_phy),
    .rx_phy    (rx_phy),
    .r_credit  (r_credit),
    .b_credit  (b_credit)
  );

endmodule

`default_nettype wire

/* design/phy_packer.sv */
// Packs the R and B pushes into the registered transmit PHY word
// and registers the credit-return bits taken from the receive word

`timescale 1ns/1ps
`default_nettype none

module phy_packer
  import axi_resp_pkg::*;
  import link_pkg::*;
(
  input  logic         clk_wr,
  input  logic         rst_n,

  // From the channels
  input  logic         r_push,
  input  r_payload_t   r_payload,
  input  logic         b_push,
  input  b_payload_t   b_payload,

  // PHY
  output tx_phy_word_t tx_phy,
  input  rx_phy_word_t rx_phy,

  // Back to the channels
  output logic         r_credit,
  output logic         b_credit
);

  ////////////////////
  // Transmit word
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy.pad    <= '0;
      tx_phy.r_push <= r_push;
      tx_phy.b_push <= b_push;
      // Idle fields go out as zero
      if (r_push) begin
        tx_phy.r_payload <= r_payload;
      end else begin
        tx_phy.r_payload <= '0;
      end
      if (b_push) begin
        tx_phy.b_payload <= b_payload;
      end else begin
        tx_phy.b_payload <= '0;
      end
    end
  end

  ////////////////////
  // Credit returns, one cycle after sampling
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      r_credit <= 1'b0;
      b_credit <= 1'b0;
    end else begin
      r_credit <= rx_phy.r_credit;
      b_credit <= rx_phy.b_credit;
    end
  end

endmodule

`default_nettype wire

/* design/online_delay.sv */
// Holds the link offline until tx_online has stayed high for delay_value cycles
// Its output is the online level seen by both transmit channels

`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module online_delay (
  input  logic                    clk_wr,
  input  logic                    rst_n,
  input  logic                    tx_online,
  input  logic [`DELAY_WIDTH-1:0] delay_value,
  output logic                    link_online
);

  logic [`DELAY_WIDTH-1:0] high_cnt;
  logic                    delay_done;

  // True on the sample that completes the programmed run of high cycles
  // (a value of 0 behaves like 1)
  assign delay_done = (({1'b0, high_cnt} + 1'b1) >= {1'b0, delay_value});

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      high_cnt    <= '0;
      link_online <= 1'b0;
    end else if (!tx_online) begin
      // Any low sample restarts the count
      high_cnt    <= '0;
      link_online <= 1'b0;
    end else if (!link_online) begin
      if (delay_done) begin
        link_online <= 1'b1;
      end else begin
        high_cnt <= high_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tx_channel/link_tx_channel.sv */
// One credit-controlled transmit channel with a single-beat buffer
// Instantiated once for R and once for B with their own payload width and credit limit

`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module link_tx_channel
  import link_pkg::*;
#(
  parameter int PAYLOAD_WIDTH = `R_PAYLOAD_WIDTH,
  parameter int CREDIT_MAX    = `R_CREDIT_MAX
) (
  input  logic                     clk_wr,
  input  logic                     rst_n,

  input  logic                     link_online,
  input  logic [`CREDIT_WIDTH-1:0] init_credit,

  // User side
  input  logic                     valid,
  input  logic [PAYLOAD_WIDTH-1:0] payload,
  output logic                     ready,

  // Link side
  output logic                     push,
  output logic [PAYLOAD_WIDTH-1:0] push_payload,
  input  logic                     credit_return
);

  localparam logic [`CREDIT_WIDTH-1:0] CREDIT_LIMIT = `CREDIT_WIDTH'(CREDIT_MAX);

  link_state_e              state;
  logic                     buf_full;
  logic [PAYLOAD_WIDTH-1:0] buf_payload;
  logic [`CREDIT_WIDTH-1:0] credit;
  logic [`CREDIT_WIDTH-1:0] credit_load;
  logic                     accept;
  logic                     credit_avail;

  // Take a beat only when active and the buffer is free
  assign ready        = (state == LINK_ACTIVE) && link_online && !buf_full;
  assign accept       = valid && ready;
  assign credit_avail = (credit != '0);

  // Buffered beat leaves as soon as a credit is held
  assign push         = (state == LINK_ACTIVE) && link_online && buf_full && credit_avail;
  assign push_payload = buf_payload;

  // Initial credit never exceeds what the far side can hold
  assign credit_load  = (init_credit > CREDIT_LIMIT) ? CREDIT_LIMIT : init_credit;

  ////////////////////
  // Link state machine
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      state <= LINK_OFFLINE;
    end else if (!link_online) begin
      state <= LINK_OFFLINE;
    end else begin
      case (state)
        LINK_OFFLINE: begin
          state <= LINK_LOAD_CREDIT;
        end
        LINK_LOAD_CREDIT: begin
          state <= LINK_ACTIVE;
        end
        LINK_ACTIVE: begin
          state <= LINK_ACTIVE;
        end
        default: begin
          state <= LINK_OFFLINE;
        end
      endcase
    end
  end

  ////////////////////
  // One-beat buffer, dropped when the link goes down
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      buf_full <= 1'b0;
    end else if (!link_online) begin
      buf_full <= 1'b0;
    end else if (accept) begin
      buf_full <= 1'b1;
    end else if (push) begin
      buf_full <= 1'b0;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (accept) begin
      buf_payload <= payload;
    end
  end

  ////////////////////
  // Credit counter
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      credit <= '0;
    end else begin
      case (state)
        LINK_LOAD_CREDIT: begin
          credit <= credit_load;
        end
        LINK_ACTIVE: begin
          // Push and return together cancel out
          if (push && !credit_return) begin
            credit <= credit - 1'b1;
          end else if (credit_return && !push && (credit < CREDIT_LIMIT)) begin
            credit <= credit + 1'b1;
          end
        end
        default: begin
          credit <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* common/link_pkg.sv */
// Link-side types: transmit channel state and the PHY word layouts
// Import where a module drives the link or decodes the receive word

`default_nettype none

`include "link_macros.svh"

package link_pkg;

  // Per-channel link state
  typedef enum logic [1:0] {
    LINK_OFFLINE     = 2'd0,
    LINK_LOAD_CREDIT = 2'd1,
    LINK_ACTIVE      = 2'd2
  } link_state_e;

  ////////////////////
  // Transmit word, R in the low bits and B above it
  typedef struct packed {
    logic [`LINK_PHY_WIDTH-`TX_PAD_LSB-1:0] pad;
    logic [`B_PAYLOAD_WIDTH-1:0]           b_payload;
    logic                                  b_push;
    logic [`R_PAYLOAD_WIDTH-1:0]           r_payload;
    logic                                  r_push;
  } tx_phy_word_t;

  ////////////////////
  // Receive word, only the credit returns are used here
  typedef struct packed {
    logic [`LINK_PHY_WIDTH-`RX_CREDIT_BITS-1:0] unused;
    logic                                      b_credit;
    logic                                      r_credit;
  } rx_phy_word_t;

endpackage

`default_nettype wire

/* common/axi_resp_pkg.sv */
// User-side AXI response types for the R and B channels
// Import where a module handles R or B beats as structs

`default_nettype none

`include "link_macros.svh"

package axi_resp_pkg;

  // AXI response encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  ////////////////////
  // R beat, most significant field first
  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic                       last;
    axi_resp_e                  resp;
  } r_payload_t;

  ////////////////////
  // B beat
  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0] id;
    axi_resp_e                resp;
  } b_payload_t;

endpackage

`default_nettype wire

/* common/link_macros.svh */
// Widths, credit limits and PHY bit positions for the packet slave transmit path
// Included by the packages and by any module that sizes ports from these values

`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

////////////////////
// AXI user side
`define AXI_ID_WIDTH      4
`define AXI_DATA_WIDTH    32

// id + data + last + resp
`define R_PAYLOAD_WIDTH   39
// id + resp
`define B_PAYLOAD_WIDTH   6

////////////////////
// Link side
`define LINK_PHY_WIDTH    80
`define CREDIT_WIDTH      8
`define DELAY_WIDTH       16

// Credit counter saturation per channel
`define R_CREDIT_MAX      128
`define B_CREDIT_MAX      8

// First unused bit of the transmit word, above the B payload
`define TX_PAD_LSB        47
// Credit return bits at the bottom of the receive word
`define RX_CREDIT_BITS    2

`endif
